// ==== verilog/elevator_pkg.sv ====
package elevator_pkg;

    // queue geometry
    localparam int queue_depth = 16;
    localparam int idx_w       = 4;

    // stop word layout
    localparam int floor_w = 2;
    localparam int type_w  = 2;     // type 0 reserved, keeps a live word nonzero
    localparam int entry_w = 7;     // is_origin + type + origin + dest

    // call intake sequencer
    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_pickup = 2'd1;
    localparam logic [1:0] st_drop   = 2'd2;

    // one queue slot, tested raw for empty or read field by field
    typedef union packed {
        logic [entry_w-1:0] raw;
        struct packed {
            logic               is_origin;  // set on the pickup half of a call
            logic [type_w-1:0]  obj_type;
            logic [floor_w-1:0] origin;
            logic [floor_w-1:0] dest;
        } fields;
    } stop_entry_u;

    // floor the car must visit to serve this stop
    function automatic logic [floor_w-1:0] stop_floor_of(input stop_entry_u e);
        return e.fields.is_origin ? e.fields.origin : e.fields.dest;
    endfunction

    // an all-zero word marks a free slot
    function automatic logic entry_empty(input stop_entry_u e);
        return e.raw == '0;
    endfunction

endpackage

// ==== verilog/call_intake.sv ====
`timescale 1ns/1ps

module call_intake (
    input  logic                             clk,
    input  logic                             clear,
    input  logic                             call_valid,
    input  logic [elevator_pkg::type_w-1:0]  obj_type,
    input  logic [elevator_pkg::floor_w-1:0] origin,
    input  logic [elevator_pkg::floor_w-1:0] dest,
    input  logic                             place_done,
    input  logic [elevator_pkg::idx_w-1:0]   placed_idx,
    input  logic                             place_full,
    output logic                             place_valid,
    output elevator_pkg::stop_entry_u        place_entry,
    output logic [elevator_pkg::idx_w-1:0]   start_idx,
    output logic                             busy,
    output logic                             call_dropped
);
    import elevator_pkg::*;

    logic [1:0]         state;
    logic [type_w-1:0]  call_type;      // held for both stops
    logic [floor_w-1:0] call_origin;
    logic [floor_w-1:0] call_dest;
    logic               accept;

    assign busy   = state != st_idle;
    assign accept = call_valid && !busy && obj_type != '0;  // type 0 would read as empty

    // both stops carry the whole call, is_origin selects which floor counts
    always_comb begin
        place_entry.fields.is_origin = (state == st_pickup);
        place_entry.fields.obj_type  = call_type;
        place_entry.fields.origin    = call_origin;
        place_entry.fields.dest      = call_dest;
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            state        <= st_idle;
            place_valid  <= 1'b0;
            start_idx    <= '0;
            call_dropped <= 1'b0;
        end else begin
            place_valid  <= 1'b0;
            call_dropped <= call_valid && !accept;     // busy or reserved type
            case (state)
                st_idle: begin
                    if (accept) begin
                        state       <= st_pickup;
                        place_valid <= 1'b1;
                        start_idx   <= '0;              // pickup may go anywhere
                    end
                end
                st_pickup: begin
                    if (place_done) begin
                        // no room behind a pickup in the last slot either
                        if (place_full || placed_idx == idx_w'(queue_depth - 1)) begin
                            state        <= st_idle;
                            call_dropped <= 1'b1;
                        end else begin
                            state       <= st_drop;
                            place_valid <= 1'b1;
                            start_idx   <= placed_idx + 1'b1;  // drop-off after its pickup
                        end
                    end
                end
                st_drop: begin
                    if (place_done) begin
                        state <= st_idle;
                        if (place_full) call_dropped <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            call_type   <= obj_type;
            call_origin <= origin;
            call_dest   <= dest;
        end
    end

    // the planner only ever answers a request issued from here
    a_done_in_call: assert property (@(posedge clk) disable iff (clear)
        place_done |-> state != st_idle);

endmodule

// ==== verilog/insert_planner.sv ====
`timescale 1ns/1ps

module insert_planner (
    input  logic                             clk,
    input  logic                             clear,
    input  logic                             place_valid,
    input  elevator_pkg::stop_entry_u        place_entry,
    input  logic [elevator_pkg::idx_w-1:0]   start_idx,
    input  logic [elevator_pkg::floor_w-1:0] cur_floor,
    input  elevator_pkg::stop_entry_u        scan_entry,
    input  elevator_pkg::stop_entry_u        prev_entry,
    output logic [elevator_pkg::idx_w-1:0]   scan_idx,
    output logic                             append,
    output logic                             fit,
    output logic [elevator_pkg::idx_w-1:0]   fit_idx,
    output elevator_pkg::stop_entry_u        new_entry,
    output logic                             place_done,
    output logic [elevator_pkg::idx_w-1:0]   placed_idx,
    output logic                             place_full
);
    import elevator_pkg::*;

    logic               run;            // scan in progress
    logic [floor_w-1:0] prev_floor;     // where the car is before slot k
    logic [floor_w-1:0] slot_floor;
    logic [floor_w-1:0] new_floor;
    logic               slot_empty;
    logic               between;
    logic               at_end;
    logic               decide;

    assign fit_idx = scan_idx;  // insert point is the slot under examination

    always_comb begin
        prev_floor = (scan_idx == '0) ? cur_floor : stop_floor_of(prev_entry);
        slot_floor = stop_floor_of(scan_entry);
        new_floor  = stop_floor_of(new_entry);
        slot_empty = entry_empty(scan_entry);
        // stop lies on the leg p -> q in either direction
        between    = ((prev_floor < new_floor) && (new_floor < slot_floor)) ||
                     ((slot_floor < new_floor) && (new_floor < prev_floor));
    end

    assign append = run && slot_empty;
    assign fit    = run && !slot_empty && between;
    assign at_end = run && !slot_empty && !between &&
                    scan_idx == idx_w'(queue_depth - 1);
    assign decide = append || fit || at_end;

    // a fit into a full queue pushes the last stop out, as the store does
    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            run        <= 1'b0;
            scan_idx   <= '0;
            place_done <= 1'b0;
            place_full <= 1'b0;
        end else begin
            place_done <= 1'b0;
            place_full <= 1'b0;
            if (place_valid) begin
                run      <= 1'b1;
                scan_idx <= start_idx;
            end else if (run) begin
                if (decide) begin
                    run        <= 1'b0;
                    place_done <= 1'b1;     // same edge as the queue write
                    place_full <= at_end;
                end else begin
                    scan_idx <= scan_idx + 1'b1;    // one slot per cycle
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (place_valid) new_entry <= place_entry;
        if (run && decide) placed_idx <= scan_idx;
    end

    // the scan never walks past a free slot of the packed queue
    a_scan_packed: assert property (@(posedge clk) disable iff (clear)
        run |-> (scan_idx == '0 || !entry_empty(prev_entry)));

    // intake waits for place_done before the next request
    a_no_overlap: assert property (@(posedge clk) disable iff (clear)
        place_valid |-> !run);

endmodule

// ==== verilog/stop_queue.sv ====
`timescale 1ns/1ps

module stop_queue (
    input  logic                           clk,
    input  logic                           clear,
    input  logic                           append,
    input  logic                           fit,
    input  logic [elevator_pkg::idx_w-1:0] fit_idx,
    input  elevator_pkg::stop_entry_u      new_entry,
    input  logic                           shift,
    input  logic [elevator_pkg::idx_w-1:0] scan_idx,
    output elevator_pkg::stop_entry_u      scan_entry,
    output elevator_pkg::stop_entry_u      prev_entry,
    output elevator_pkg::stop_entry_u      head_entry
);
    import elevator_pkg::*;

    stop_entry_u        slots [queue_depth];
    logic [idx_w-1:0]   prev_idx;
    logic [idx_w-1:0]   free_idx;       // first empty slot
    logic               has_free;

    assign prev_idx = scan_idx - 1'b1;  // wraps at 0, planner uses cur_floor there

    assign scan_entry = slots[scan_idx];
    assign prev_entry = slots[prev_idx];
    assign head_entry = slots[0];

    // entries stay packed at the front, so this is also the fill level
    always_comb begin
        free_idx = idx_w'(queue_depth - 1);
        has_free = 1'b0;
        for (int i = 0; i < queue_depth; i++) begin
            if (!has_free && entry_empty(slots[i])) begin
                free_idx = idx_w'(i);
                has_free = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            for (int i = 0; i < queue_depth; i++) begin
                slots[i] <= '0;
            end
        end else if (shift) begin
            // pop the head, tail slot opens up
            for (int i = 0; i < queue_depth - 1; i++) begin
                slots[i] <= slots[i + 1];
            end
            slots[queue_depth - 1] <= '0;
        end else if (fit) begin
            // make room at fit_idx, last entry falls off if full
            for (int i = 1; i < queue_depth; i++) begin
                if (i > int'(fit_idx)) slots[i] <= slots[i - 1];
            end
            slots[fit_idx] <= new_entry;
        end else if (append && has_free) begin
            slots[free_idx] <= new_entry;
        end
    end

    // dispatcher holds arrivals while the planner works
    a_shift_alone: assert property (@(posedge clk) disable iff (clear)
        !(shift && (append || fit)));

    // planner appends only where the packed queue ends
    a_append_tail: assert property (@(posedge clk) disable iff (clear)
        append |-> has_free && free_idx == scan_idx);

endmodule

// ==== verilog/stop_dispatcher.sv ====
`timescale 1ns/1ps

module stop_dispatcher (
    input  logic                             clk,
    input  logic                             clear,
    input  logic                             arrive,
    input  logic                             busy,
    input  elevator_pkg::stop_entry_u        head_entry,
    output logic                             shift,
    output logic [elevator_pkg::floor_w-1:0] cur_floor,
    output logic                             stop_valid,
    output logic [elevator_pkg::floor_w-1:0] stop_floor,
    output logic                             stop_is_origin,
    output logic [elevator_pkg::type_w-1:0]  stop_type,
    output logic                             queue_empty
);
    import elevator_pkg::*;

    logic pending;      // arrival waiting for the planner to finish
    logic serve;
    logic pop;

    assign queue_empty = entry_empty(head_entry);

    // head is stale while a shift is still in flight
    assign serve = (arrive || pending) && !busy && !shift;
    assign pop   = serve && !queue_empty;   // arrival at an empty queue reports nothing

    assign stop_valid = shift;  // report goes out with the pop

    always_ff @(posedge clk or posedge clear) begin
        if (clear) begin
            pending   <= 1'b0;
            shift     <= 1'b0;
            cur_floor <= '0;
        end else begin
            shift <= pop;
            if (serve) begin
                pending <= 1'b0;
            end else if (arrive) begin
                pending <= 1'b1;
            end
            if (pop) cur_floor <= stop_floor_of(head_entry);
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            stop_floor     <= stop_floor_of(head_entry);
            stop_is_origin <= head_entry.fields.is_origin;
            stop_type      <= head_entry.fields.obj_type;
        end
    end

endmodule

// ==== verilog/elevator_queue_top.sv ====
`timescale 1ns/1ps

module elevator_queue_top (
    input  logic                             clk,
    input  logic                             clear,
    input  logic                             call_valid,
    input  logic [elevator_pkg::type_w-1:0]  obj_type,
    input  logic [elevator_pkg::floor_w-1:0] origin,
    input  logic [elevator_pkg::floor_w-1:0] dest,
    input  logic                             arrive,
    output logic                             stop_valid,
    output logic [elevator_pkg::floor_w-1:0] stop_floor,
    output logic                             stop_is_origin,
    output logic [elevator_pkg::type_w-1:0]  stop_type,
    output logic                             queue_empty,
    output logic                             busy,
    output logic                             call_dropped
);
    import elevator_pkg::*;

    // intake to planner
    logic               place_valid;
    stop_entry_u        place_entry;
    logic [idx_w-1:0]   start_idx;
    logic               place_done;
    logic [idx_w-1:0]   placed_idx;
    logic               place_full;

    // planner to queue
    logic [idx_w-1:0]   scan_idx;
    stop_entry_u        scan_entry;
    stop_entry_u        prev_entry;
    logic               append;
    logic               fit;
    logic [idx_w-1:0]   fit_idx;
    stop_entry_u        new_entry;

    // dispatcher side
    logic               shift;
    stop_entry_u        head_entry;
    logic [floor_w-1:0] cur_floor;

    call_intake u_intake (
        .clk, .clear,
        .call_valid, .obj_type, .origin, .dest,
        .place_done, .placed_idx, .place_full,
        .place_valid, .place_entry, .start_idx,
        .busy, .call_dropped
    );

    insert_planner u_planner (
        .clk, .clear,
        .place_valid, .place_entry, .start_idx, .cur_floor,
        .scan_entry, .prev_entry, .scan_idx,
        .append, .fit, .fit_idx, .new_entry,
        .place_done, .placed_idx, .place_full
    );

    stop_queue u_queue (
        .clk, .clear,
        .append, .fit, .fit_idx, .new_entry, .shift, .scan_idx,
        .scan_entry, .prev_entry, .head_entry
    );

    stop_dispatcher u_dispatch (
        .clk, .clear,
        .arrive, .busy, .head_entry,
        .shift, .cur_floor,
        .stop_valid, .stop_floor, .stop_is_origin, .stop_type, .queue_empty
    );

endmodule

// ==== dv/elevator_queue_tb.sv ====
`timescale 1ns/1ps

module elevator_queue_tb;

    localparam int depth      = 16;
    localparam int wait_limit = 60;     // cycles per wait, far above a 17-slot scan

    localparam logic [2:0] k_empty = 3'd0;  // arrival with nothing queued
    localparam logic [2:0] k_call  = 3'd1;
    localparam logic [2:0] k_busy  = 3'd2;  // call followed by one strobed while busy
    localparam logic [2:0] k_burst = 3'd3;  // cnt random calls
    localparam logic [2:0] k_drain = 3'd4;  // arrivals until the model is empty

    // {kind, type, origin, dest, cnt}
    localparam int n_rows = 11;
    localparam logic [16:0] table_rows [n_rows] = '{
        {k_empty, 2'd0, 2'd0, 2'd0, 8'd0},
        {k_call,  2'd1, 2'd2, 2'd0, 8'd0},      // pickup at 2, drop-off at 0
        {k_drain, 2'd0, 2'd0, 2'd0, 8'd0},
        {k_call,  2'd2, 2'd0, 2'd3, 8'd0},
        {k_call,  2'd3, 2'd1, 2'd2, 8'd0},      // both stops fall inside 0 -> 3
        {k_drain, 2'd0, 2'd0, 2'd0, 8'd0},
        {k_busy,  2'd1, 2'd3, 2'd1, 8'd0},
        {k_drain, 2'd0, 2'd0, 2'd0, 8'd0},
        {k_burst, 2'd0, 2'd0, 2'd0, 8'd14},     // overfills the 16 slots
        {k_drain, 2'd0, 2'd0, 2'd0, 8'd0},
        {k_empty, 2'd0, 2'd0, 2'd0, 8'd0}
    };

    logic       clk, clear, call_valid, arrive;
    logic [1:0] obj_type, origin, dest;
    logic       stop_valid, stop_is_origin, queue_empty, busy, call_dropped;
    logic [1:0] stop_floor, stop_type;

    logic [6:0] model_q [$];    // {is_origin, type, origin, dest}
    logic [1:0] model_floor;
    int         exp_drops, seen_drops, exp_stops, seen_stops;
    int         errors, timeouts;

    elevator_queue_top UUT (.*);

    always #20 clk = ~clk;

    // strobes are counted mid-cycle
    always @(negedge clk) begin
        if (call_dropped) seen_drops++;
        if (stop_valid) seen_stops++;
    end

    function automatic logic [1:0] floor_of(input logic [6:0] e);
        return e[6] ? e[3:2] : e[1:0];
    endfunction

    // places one stop on the model route and returns its slot or -1
    function automatic int place_stop(input logic [6:0] e, input int start);
        logic [1:0] f;
        logic [1:0] p;
        logic [1:0] q;
        f = floor_of(e);
        for (int k = start; k < depth; k++) begin
            if (k == 0) p = model_floor;
            else p = floor_of(model_q[k - 1]);
            if (k >= model_q.size()) begin
                model_q.push_back(e);
                return k;
            end
            q = floor_of(model_q[k]);
            if ((p < f && f < q) || (q < f && f < p)) begin
                model_q.insert(k, e);
                if (model_q.size() > depth) model_q.delete(depth);  // tail stop falls off
                return k;
            end
        end
        return -1;
    endfunction

    task automatic model_call(input logic [1:0] t, input logic [1:0] o, input logic [1:0] d);
        int idx;
        idx = place_stop({1'b1, t, o, d}, 0);
        if (idx < 0 || idx == depth - 1) exp_drops++;  // no slot left behind the pickup
        else if (place_stop({1'b0, t, o, d}, idx + 1) < 0) exp_drops++;
    endtask

    task automatic check_value(input string name, input string what, input int exp, input int act);
        assert (exp == act) else begin
            errors++;
            $display("error %s: %s expected %0d actual %0d", name, what, exp, act);
        end
    endtask

    task automatic issue_call(input string name, input logic [1:0] t, input logic [1:0] o,
                              input logic [1:0] d, input logic extra);
        int n;
        model_call(t, o, d);
        @(posedge clk);
        #1;
        call_valid = 1'b1;
        obj_type   = t;
        origin     = o;
        dest       = d;
        @(posedge clk);
        #1;
        if (extra) begin
            check_value(name, "busy under second call", 1, int'(busy));
            exp_drops++;
            obj_type = 2'd3;    // a 0 -> 3 call that would fit if taken
            origin   = 2'd0;
            dest     = 2'd3;
            @(posedge clk);
            #1;
        end
        call_valid = 1'b0;
        n = 0;
        while (busy && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            timeouts++;
            $display("%s: busy still high after %0d cycles", name, wait_limit);
        end
        repeat (2) @(negedge clk);
        check_value(name, "dropped calls", exp_drops, seen_drops);
    endtask

    task automatic strobe_arrival(input string name);
        logic [6:0] head;
        logic       want;
        logic       seen;
        int         n;
        want = model_q.size() > 0;
        head = '0;
        if (want) head = model_q[0];
        @(posedge clk);
        #1;
        arrive = 1'b1;
        @(negedge clk);
        check_value(name, "stop_valid with arrive", 0, int'(stop_valid));
        @(posedge clk);
        #1;
        arrive = 1'b0;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 4) begin
            @(negedge clk);
            n++;
            seen = stop_valid;
        end
        if (!want) begin
            check_value(name, "stop_valid on empty queue", 0, int'(seen));
        end else if (!seen) begin
            timeouts++;
            $display("%s: no stop reported after the arrival", name);
        end else begin
            exp_stops++;
            check_value(name, "arrival latency", 1, n);
            check_value(name, "stop_floor", int'(floor_of(head)), int'(stop_floor));
            check_value(name, "stop_is_origin", int'(head[6]), int'(stop_is_origin));
            check_value(name, "stop_type", int'(head[5:4]), int'(stop_type));
            model_floor = floor_of(head);
            model_q.delete(0);
            @(negedge clk);     // head moves up one edge after the report
        end
        check_value(name, "queue_empty", int'(model_q.size() == 0), int'(queue_empty));
    endtask

    initial begin
        logic [16:0] row;
        logic [1:0]  rt, ro, rd;
        string       name;
        clk         = 1'b0;
        clear       = 1'b1;
        call_valid  = 1'b0;
        arrive      = 1'b0;
        obj_type    = '0;
        origin      = '0;
        dest        = '0;
        model_floor = '0;
        void'($urandom(82263));
        repeat (2) @(posedge clk);
        #1;
        clear = 1'b0;
        @(negedge clk);
        check_value("reset", "busy", 0, int'(busy));
        check_value("reset", "call_dropped", 0, int'(call_dropped));
        check_value("reset", "stop_valid", 0, int'(stop_valid));
        check_value("reset", "queue_empty", 1, int'(queue_empty));

        for (int i = 0; i < n_rows; i++) begin
            row  = table_rows[i];
            name = $sformatf("row%0d", i);
            case (row[16:14])
                k_empty: begin
                    check_value(name, "queue_empty before arrival", 1, int'(queue_empty));
                    strobe_arrival(name);
                end
                k_call: issue_call(name, row[13:12], row[11:10], row[9:8], 1'b0);
                k_busy: issue_call(name, row[13:12], row[11:10], row[9:8], 1'b1);
                k_burst: begin
                    for (int c = 0; c < int'(row[7:0]); c++) begin
                        rt = 2'($urandom_range(2)) + 2'd1;     // type 0 is reserved
                        ro = 2'($urandom_range(3));
                        rd = 2'($urandom_range(3));
                        issue_call($sformatf("row%0d_call%0d", i, c), rt, ro, rd, 1'b0);
                    end
                end
                k_drain: begin
                    for (int c = 0; c < 2 * depth && model_q.size() > 0; c++) begin
                        strobe_arrival(name);
                    end
                    if (model_q.size() > 0) begin
                        timeouts++;
                        $display("%s: queue did not drain", name);
                    end
                end
                default: ;
            endcase
        end

        check_value("end", "reported stops", exp_stops, seen_stops);
        check_value("end", "dropped calls", exp_drops, seen_drops);
        $display("errors: %0d value mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/elevator_pkg.sv
verilog/call_intake.sv
verilog/insert_planner.sv
verilog/stop_queue.sv
verilog/stop_dispatcher.sv
verilog/elevator_queue_top.sv
dv/elevator_queue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the elevator stop scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module elevator_queue_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Velevator_queue_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
exit 1
